// ==== source/uart_cmd_pkg.sv ====
package uart_cmd_pkg;

  // host command, bit 15 is the write flag
  typedef logic [15:0] cmd_t;

  // one byte carried in a serial frame
  typedef logic [7:0] uart_byte_t;

  // returned read word, bit 8 flags a parity error
  typedef logic [8:0] read_word_t;

  typedef enum logic [1:0] {
    idle,
    push_low,
    wait_resp
  } framer_state_e;

  // start, 8 data, parity, stop
  localparam int frame_bits = 11;

endpackage

// ==== source/uart_byte_fifo.sv ====
`timescale 1ns/1ps

module uart_byte_fifo #(
  parameter int fifo_depth = 8
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                push,
  input  uart_cmd_pkg::uart_byte_t            push_data,
  input  logic                                pop,
  output uart_cmd_pkg::uart_byte_t            pop_data,
  output logic                                empty,
  output logic [$clog2(fifo_depth + 1)-1:0]   fill_level
);

  localparam int addr_w = $clog2(fifo_depth);

  uart_cmd_pkg::uart_byte_t          mem [fifo_depth];
  logic [addr_w-1:0]                 wr_ptr;
  logic [addr_w-1:0]                 rd_ptr;
  logic [$clog2(fifo_depth + 1)-1:0] count;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // depth is a power of two so the pointers wrap on their own
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign pop_data   = mem[rd_ptr];
  assign empty      = (count == '0);
  assign fill_level = count;

  assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty);

  assert property (@(posedge clk) disable iff (!rst_n) push |-> (count != fifo_depth));

endmodule

// ==== source/uart_cmd_framer.sv ====
`timescale 1ns/1ps

module uart_cmd_framer #(
  parameter int fifo_depth = 8
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  uart_cmd_pkg::cmd_t                  cmd_in,
  input  logic                                cmd_vld,
  output logic                                cmd_rdy,
  output logic                                push,
  output uart_cmd_pkg::uart_byte_t            push_data,
  input  logic [$clog2(fifo_depth + 1)-1:0]   fill_level,
  input  logic                                frame_done,
  input  logic                                rx_valid
);

  uart_cmd_pkg::framer_state_e state;
  uart_cmd_pkg::framer_state_e state_nxt;
  uart_cmd_pkg::uart_byte_t    low_q;
  logic                        accept;
  logic                        room;
  logic                        sent_now;
  logic                        req_sent;
  logic                        resp_seen;

  // cmd_rdy is only ever high in idle
  assign accept = cmd_vld && cmd_rdy;

  assign push      = accept || (state == uart_cmd_pkg::push_low);
  assign push_data = (state == uart_cmd_pkg::push_low) ? low_q : cmd_in[15:8];

  // room for a full command once this cycle's push has landed
  assign room = (int'(fill_level) + int'(push)) <= (fifo_depth - 2);

  // read byte is the last one queued, so an empty FIFO at frame end means it left
  assign sent_now = frame_done && (fill_level == '0);

  always_comb begin
    state_nxt = state;
    case (state)
      uart_cmd_pkg::idle: begin
        if (accept) begin
          state_nxt = cmd_in[15] ? uart_cmd_pkg::push_low : uart_cmd_pkg::wait_resp;
        end
      end
      uart_cmd_pkg::push_low: begin
        state_nxt = uart_cmd_pkg::idle;
      end
      uart_cmd_pkg::wait_resp: begin
        if ((req_sent || sent_now) && (resp_seen || rx_valid)) begin
          state_nxt = uart_cmd_pkg::idle;
        end
      end
      default: begin
        state_nxt = uart_cmd_pkg::idle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= uart_cmd_pkg::idle;
      cmd_rdy   <= 1'b1;
      req_sent  <= 1'b0;
      resp_seen <= 1'b0;
    end else begin
      state   <= state_nxt;
      cmd_rdy <= (state_nxt == uart_cmd_pkg::idle) && room;
      if (accept) begin
        req_sent  <= 1'b0;
        resp_seen <= 1'b0;
      end else if (state == uart_cmd_pkg::wait_resp) begin
        if (sent_now) begin
          req_sent <= 1'b1;
        end
        if (rx_valid) begin
          resp_seen <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      low_q <= cmd_in[7:0];
    end
  end

  // room test must keep the FIFO from ever overflowing
  assert property (@(posedge clk) disable iff (!rst_n)
    !(push && (fill_level == fifo_depth)));

endmodule

// ==== source/uart_tx_serializer.sv ====
`timescale 1ns/1ps

module uart_tx_serializer #(
  parameter int clks_per_bit = 434
) (
  input  logic                     clk,
  input  logic                     rst_n,
  output logic                     pop,
  input  uart_cmd_pkg::uart_byte_t pop_data,
  input  logic                     empty,
  output logic                     tx,
  output logic                     frame_done
);

  localparam int cnt_w = $clog2(clks_per_bit);
  localparam int bit_w = $clog2(uart_cmd_pkg::frame_bits);

  localparam logic [cnt_w-1:0] tick_last = cnt_w'(clks_per_bit - 1);
  localparam logic [cnt_w-1:0] tick_prev = cnt_w'(clks_per_bit - 2);
  localparam logic [bit_w-1:0] stop_idx  = bit_w'(uart_cmd_pkg::frame_bits - 1);

  logic [uart_cmd_pkg::frame_bits-1:0] shreg;
  logic                                busy;
  logic [cnt_w-1:0]                    baud_cnt;
  logic [bit_w-1:0]                    bit_cnt;
  logic                                bit_end;
  logic                                frame_end;
  logic                                near_end;

  assign bit_end   = busy && (baud_cnt == tick_last);
  assign frame_end = bit_end && (bit_cnt == stop_idx);
  // last cycle of the stop bit starts on the next edge
  assign near_end  = busy && (bit_cnt == stop_idx) && (baud_cnt == tick_prev);

  // line follows the low end of the shift register
  assign tx = shreg[0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pop        <= 1'b0;
      frame_done <= 1'b0;
      busy       <= 1'b0;
      baud_cnt   <= '0;
      bit_cnt    <= '0;
      shreg      <= '1;
    end else begin
      // pop ahead of the frame end so frames run back to back
      pop        <= !pop && !empty && (!busy || near_end);
      frame_done <= near_end;
      if (pop) begin
        busy     <= 1'b1;
        baud_cnt <= '0;
        bit_cnt  <= '0;
        shreg    <= {1'b1, ~^pop_data, pop_data, 1'b0};
      end else if (frame_end) begin
        busy     <= 1'b0;
        baud_cnt <= '0;
      end else if (bit_end) begin
        baud_cnt <= '0;
        bit_cnt  <= bit_cnt + 1'b1;
        shreg    <= {1'b1, shreg[uart_cmd_pkg::frame_bits-1:1]};
      end else if (busy) begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

  // stop bit comes from the loaded frame, not the idle level
  assert property (@(posedge clk) disable iff (!rst_n)
    (busy && (bit_cnt == stop_idx)) |-> tx);

endmodule

// ==== source/uart_rx_deserializer.sv ====
`timescale 1ns/1ps

module uart_rx_deserializer #(
  parameter int clks_per_bit = 434,
  parameter bit check_parity = 1'b1
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     rx,
  output uart_cmd_pkg::read_word_t rx_word,
  output logic                     rx_valid
);

  localparam int cnt_w = $clog2(clks_per_bit);
  localparam int bit_w = $clog2(uart_cmd_pkg::frame_bits);

  localparam logic [cnt_w-1:0] tick_last = cnt_w'(clks_per_bit - 1);
  localparam logic [cnt_w-1:0] tick_half = cnt_w'(clks_per_bit / 2 - 1);
  localparam logic [bit_w-1:0] par_idx   = bit_w'(uart_cmd_pkg::frame_bits - 2);
  localparam logic [bit_w-1:0] stop_idx  = bit_w'(uart_cmd_pkg::frame_bits - 1);

  logic                     rx_meta;
  logic                     rx_sync;
  logic                     rx_prev;
  logic                     fall;
  logic                     active;
  logic                     sample;
  logic [cnt_w-1:0]         baud_cnt;
  logic [bit_w-1:0]         bit_idx;
  uart_cmd_pkg::uart_byte_t data_sr;
  logic                     par_bit;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign fall = rx_prev && !rx_sync;

  // start bit checked at half a bit, the rest at full bit steps
  assign sample = active &&
                  ((bit_idx == '0) ? (baud_cnt == tick_half) : (baud_cnt == tick_last));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active   <= 1'b0;
      baud_cnt <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (!active) begin
        baud_cnt <= '0;
        bit_idx  <= '0;
        if (fall) begin
          active <= 1'b1;
        end
      end else if (sample) begin
        baud_cnt <= '0;
        bit_idx  <= bit_idx + 1'b1;
        // line back high at mid start, treat as a glitch
        if ((bit_idx == '0) && rx_sync) begin
          active <= 1'b0;
        end
        if (bit_idx == stop_idx) begin
          active   <= 1'b0;
          rx_valid <= 1'b1;
        end
      end else begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sample) begin
      if ((bit_idx != '0) && (bit_idx < par_idx)) begin
        data_sr <= {rx_sync, data_sr[7:1]};
      end
      if (bit_idx == par_idx) begin
        par_bit <= rx_sync;
      end
      // stop level is not checked
      if (bit_idx == stop_idx) begin
        rx_word <= {check_parity && !(^{data_sr, par_bit}), data_sr};
      end
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) rx_valid |=> !rx_valid);

endmodule

// ==== source/uart_cmd_bridge.sv ====
`timescale 1ns/1ps

module uart_cmd_bridge #(
  parameter int clk_freq_hz  = 50_000_000,
  parameter int baud_rate    = 115_200,
  parameter bit check_parity = 1'b1,
  parameter int fifo_depth   = 8
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  uart_cmd_pkg::cmd_t       cmd_in,
  input  logic                     cmd_vld,
  output logic                     cmd_rdy,
  input  logic                     rx,
  output logic                     tx,
  output uart_cmd_pkg::read_word_t read_data,
  output logic                     read_rdy
);

  // rounded to the nearest whole clock
  localparam int clks_per_bit = (clk_freq_hz + baud_rate / 2) / baud_rate;
  localparam int fill_w       = $clog2(fifo_depth + 1);

  logic                     push;
  uart_cmd_pkg::uart_byte_t push_data;
  logic                     pop;
  uart_cmd_pkg::uart_byte_t pop_data;
  logic                     empty;
  logic [fill_w-1:0]        fill_level;
  logic                     frame_done;

  uart_cmd_framer #(
    .fifo_depth (fifo_depth)
  ) i_framer (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_in     (cmd_in),
    .cmd_vld    (cmd_vld),
    .cmd_rdy    (cmd_rdy),
    .push       (push),
    .push_data  (push_data),
    .fill_level (fill_level),
    .frame_done (frame_done),
    .rx_valid   (read_rdy)
  );

  uart_byte_fifo #(
    .fifo_depth (fifo_depth)
  ) i_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .push       (push),
    .push_data  (push_data),
    .pop        (pop),
    .pop_data   (pop_data),
    .empty      (empty),
    .fill_level (fill_level)
  );

  uart_tx_serializer #(
    .clks_per_bit (clks_per_bit)
  ) i_tx (
    .clk        (clk),
    .rst_n      (rst_n),
    .pop        (pop),
    .pop_data   (pop_data),
    .empty      (empty),
    .tx         (tx),
    .frame_done (frame_done)
  );

  uart_rx_deserializer #(
    .clks_per_bit (clks_per_bit),
    .check_parity (check_parity)
  ) i_rx (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .rx_word  (read_data),
    .rx_valid (read_rdy)
  );

endmodule

// ==== sim/tb_uart_cmd_bridge.sv ====
`timescale 1ns/1ps

module tb_uart_cmd_bridge;

  localparam int clks_per_bit = 8;
  localparam int bit_ns       = clks_per_bit * 40;
  // upper bound, every mixed command counted as a write
  localparam int total_frames = 68;
  localparam int cycle_limit  = 2 * total_frames * 88 + 2000;

  logic                     clk;
  logic                     rst_n;
  uart_cmd_pkg::cmd_t       cmd_in;
  logic                     cmd_vld;
  logic                     cmd_rdy;
  logic                     rx;
  logic                     tx;
  uart_cmd_pkg::read_word_t read_data;
  logic                     read_rdy;

  integer     seed = 81;
  int         cycles;
  int         n_exp;
  int         n_got;
  int         n_reads;
  int         rd_pulses;
  int         max_wait;
  // {stop, parity, data}
  logic [9:0] exp_q[$];
  logic [9:0] rx_q[$];

  uart_cmd_bridge #(
    .clk_freq_hz  (25_000_000),
    .baud_rate    (3_125_000),
    .check_parity (1'b1),
    .fifo_depth   (8)
  ) i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rx        (rx),
    .tx        (tx),
    .read_data (read_data),
    .read_rdy  (read_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("FAIL %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  function automatic logic odd_parity(input uart_cmd_pkg::uart_byte_t b);
    return ~(^b);
  endfunction

  // high byte always, low byte only for writes
  function automatic int expected_bytes(input uart_cmd_pkg::cmd_t cmd,
                                        output uart_cmd_pkg::uart_byte_t b_hi,
                                        output uart_cmd_pkg::uart_byte_t b_lo);
    b_hi = cmd[15:8];
    b_lo = cmd[7:0];
    return cmd[15] ? 2 : 1;
  endfunction

  // entered and left just after a rising edge
  task automatic issue_cmd(input uart_cmd_pkg::cmd_t cmd, input bit hold);
    uart_cmd_pkg::uart_byte_t b_hi;
    uart_cmd_pkg::uart_byte_t b_lo;
    int                       n;
    int                       waited;
    logic                     rdy;
    waited  = 0;
    cmd_in  = cmd;
    cmd_vld = 1'b1;
    do begin
      @(negedge clk);
      rdy = cmd_rdy;
      @(posedge clk);
      waited++;
    end while (!rdy);
    #2;
    if (!hold) begin
      cmd_vld = 1'b0;
    end
    if (waited > max_wait) begin
      max_wait = waited;
    end
    n = expected_bytes(cmd, b_hi, b_lo);
    exp_q.push_back({1'b1, odd_parity(b_hi), b_hi});
    if (n == 2) begin
      exp_q.push_back({1'b1, odd_parity(b_lo), b_lo});
    end
    n_exp += n;
  endtask

  task automatic send_rx_frame(input uart_cmd_pkg::uart_byte_t b, input bit corrupt);
    logic [10:0] frame;
    frame = {1'b1, odd_parity(b) ^ corrupt, b, 1'b0};
    for (int i = 0; i < 11; i++) begin
      rx = frame[i];
      repeat (clks_per_bit) @(posedge clk);
      #2;
    end
  endtask

  task automatic wait_tx_drained();
    while (n_got != n_exp) @(negedge clk);
    @(posedge clk);
    #2;
  endtask

  task automatic do_read(input uart_cmd_pkg::cmd_t cmd, input uart_cmd_pkg::uart_byte_t resp,
                         input bit corrupt);
    issue_cmd(cmd, 1'b0);
    n_reads++;
    // answer only once the request byte is out
    wait_tx_drained();
    fork
      send_rx_frame(resp, corrupt);
      begin
        @(negedge clk);
        while (!read_rdy) begin
          compare_value("cmd_rdy", cmd_rdy, 0);
          @(negedge clk);
        end
        compare_value("cmd_rdy", cmd_rdy, 0);
        compare_value("read_data", read_data, {corrupt, resp});
      end
    join
    while (!cmd_rdy) @(negedge clk);
    @(posedge clk);
    #2;
  endtask

  // tx frame decoder, samples at mid-bit
  initial begin
    logic [9:0] word;
    @(posedge rst_n);
    forever begin
      @(negedge tx);
      #(bit_ns / 2 + 10);
      compare_value("tx start bit", tx, 0);
      for (int i = 0; i < 10; i++) begin
        #(bit_ns);
        word[i] = tx;
      end
      rx_q.push_back(word);
    end
  end

  initial begin
    logic [9:0] got;
    logic [9:0] want;
    forever begin
      @(negedge clk);
      while (rx_q.size() != 0) begin
        got = rx_q.pop_front();
        if (exp_q.size() == 0) begin
          stop_with_failure("a frame appeared on tx that no command asked for");
        end
        want = exp_q.pop_front();
        compare_value("tx data", got[7:0], want[7:0]);
        compare_value("tx parity", got[8], want[8]);
        compare_value("tx stop bit", got[9], want[9]);
        n_got++;
      end
    end
  end

  always @(negedge clk) begin
    if (read_rdy) begin
      rd_pulses++;
    end
  end

  initial begin
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles >= cycle_limit) begin
        stop_with_failure($sformatf("timeout, tests still running after %0d cycles", cycles));
      end
    end
  end

  initial begin
    uart_cmd_pkg::cmd_t       cmd;
    uart_cmd_pkg::uart_byte_t resp;
    bit                       corrupt;
    rst_n     = 1'b0;
    cmd_in    = '0;
    cmd_vld   = 1'b0;
    rx        = 1'b1;
    n_exp     = 0;
    n_got     = 0;
    n_reads   = 0;
    rd_pulses = 0;
    max_wait  = 0;
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    compare_value("tx", tx, 1);
    compare_value("cmd_rdy", cmd_rdy, 1);
    compare_value("read_rdy", read_rdy, 0);
    @(posedge clk);
    #2;
    issue_cmd(16'hA53C, 1'b0);
    wait_tx_drained();
    // vld stays high across the whole burst
    for (int i = 0; i < 20; i++) begin
      issue_cmd({1'b1, 15'($random(seed))}, 1'b1);
    end
    cmd_vld = 1'b0;
    compare_value("cmd_rdy back-pressure", max_wait > 2, 1);
    wait_tx_drained();
    do_read(16'h3C7E, 8'h96, 1'b0);
    do_read(16'h1234, 8'h5A, 1'b1);
    for (int i = 0; i < 12; i++) begin
      cmd = uart_cmd_pkg::cmd_t'($random(seed));
      if (cmd[15]) begin
        issue_cmd(cmd, 1'b0);
      end else begin
        resp    = uart_cmd_pkg::uart_byte_t'($random(seed));
        corrupt = (($random(seed) & 3) == 0);
        do_read(cmd, resp, corrupt);
      end
    end
    wait_tx_drained();
    if (rd_pulses != n_reads) begin
      stop_with_failure($sformatf("read_rdy pulsed %0d times for %0d reads", rd_pulses, n_reads));
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule

// ==== uart_cmd_bridge.f ====
source/uart_cmd_pkg.sv
source/uart_byte_fifo.sv
source/uart_cmd_framer.sv
source/uart_tx_serializer.sv
source/uart_rx_deserializer.sv
source/uart_cmd_bridge.sv
sim/tb_uart_cmd_bridge.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_uart_cmd_bridge
FILELIST = uart_cmd_bridge.f

BIN  = obj_dir/V$(TOP)
SRCS = $(wildcard source/*.sv sim/*.sv)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# status comes from the search for the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir
